//--- logic/ncpu_isa_pkg.sv
// Instruction set definitions for the multi-cycle core
// Word and address widths, the opcode set and the instruction layout
// Referenced by scoped name from the RTL and the testbench

package ncpu_isa_pkg;

   localparam int NCPU_DW     = 32;                // Data word width
   localparam int NCPU_AW     = 16;                // Byte address width
   localparam int NCPU_REG_AW = 3;                 // Register index width
   localparam int NCPU_REGS   = 1 << NCPU_REG_AW;  // Register count
   localparam int NCPU_PCW    = NCPU_AW - 2;       // Word address width of the pc
   localparam int NCPU_IMM_W  = 16;                // Immediate field width

   // Opcodes, codes not listed decode as HALT
   typedef enum logic [3:0] {
      ADD  = 4'h0,
      SUB  = 4'h1,
      AND  = 4'h2,
      OR   = 4'h3,
      XOR  = 4'h4,
      ADDI = 4'h5,                                 // rd = rs1 + sext(imm)
      LDW  = 4'h6,                                 // rd = mem[rs1 + sext(imm)]
      STW  = 4'h7,                                 // mem[rs1 + sext(imm)] = rs2
      BEQ  = 4'h8,                                 // Branch if rs1 == rs2
      HALT = 4'hf
   } ncpu_opc_e;

   // Instruction word layout
   typedef struct packed {
      ncpu_opc_e               opcode;             // [31:28]
      logic [NCPU_REG_AW-1:0]  rd;                 // [27:25]
      logic [NCPU_REG_AW-1:0]  rs1;                // [24:22]
      logic [NCPU_REG_AW-1:0]  rs2;                // [21:19]
      logic [2:0]              rsvd;               // [18:16] Unused gap
      logic [NCPU_IMM_W-1:0]   imm;                // [15:0]
   } ncpu_insn_t;

   // Execute unit result
   typedef struct packed {
      logic [NCPU_DW-1:0] result;                  // ALU value or effective address
      logic               taken;                   // BEQ compare outcome
      logic               wb_en;                   // Opcode writes rd
   } ncpu_alu_res_t;

endpackage

//--- logic/ncpu_bus_pkg.sv
// Bus and control definitions for the multi-cycle core
// Request and response structs of the instruction and data buses
// plus the control state encoding

package ncpu_bus_pkg;

   // Instruction bus
   typedef struct packed {
      logic                             valid;     // Held until response
      logic [ncpu_isa_pkg::NCPU_AW-1:0] addr;      // Word aligned fetch address
   } ncpu_ibus_req_t;

   typedef struct packed {
      logic                             valid;     // One cycle per transfer
      logic [ncpu_isa_pkg::NCPU_DW-1:0] insn;      // Fetched instruction word
   } ncpu_ibus_rsp_t;

   // Data bus
   typedef struct packed {
      logic                             valid;     // Held until response
      logic                             we;        // Store when set
      logic [ncpu_isa_pkg::NCPU_AW-1:0] addr;      // Byte address
      logic [ncpu_isa_pkg::NCPU_DW-1:0] wdata;     // Store data
   } ncpu_dbus_req_t;

   typedef struct packed {
      logic                             valid;     // Ends load or store
      logic [ncpu_isa_pkg::NCPU_DW-1:0] rdata;     // Load data
   } ncpu_dbus_rsp_t;

   typedef enum logic [1:0] {FETCH, EXEC, MEM, HALT} ncpu_state_e;

endpackage

//--- logic/ncpu_ctrl_fsm.sv
// Control FSM of the core
// Sequences fetch, execute, memory access and halt for one instruction
// at a time and drives every strobe of the data blocks

module ncpu_ctrl_fsm (
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   input  ncpu_bus_pkg::ncpu_ibus_rsp_t ibus_rsp_i,
   output logic                        fetch_valid_o,
   output ncpu_isa_pkg::ncpu_insn_t    insn_o,
   input  ncpu_isa_pkg::ncpu_alu_res_t alu_res_i,
   input  logic                        mem_done_i,
   output logic                        pc_inc_o,
   output logic                        pc_load_o,
   output logic                        mem_start_o,
   output logic                        reg_we_o,
   output logic                        wb_sel_load_o,
   output logic                        retire_o,
   output logic                        halted_o
);
   ncpu_bus_pkg::ncpu_state_e state_q, state_d;
   logic is_alu, is_beq, is_load, is_store;        // Opcode class
   logic in_exec, in_mem;

   always_comb begin
      is_alu   = 1'b0;
      is_beq   = 1'b0;
      is_load  = 1'b0;
      is_store = 1'b0;
      case (insn_o.opcode)
         ncpu_isa_pkg::ADD, ncpu_isa_pkg::SUB, ncpu_isa_pkg::AND,
         ncpu_isa_pkg::OR, ncpu_isa_pkg::XOR, ncpu_isa_pkg::ADDI: is_alu = 1'b1;
         ncpu_isa_pkg::BEQ: is_beq   = 1'b1;
         ncpu_isa_pkg::LDW: is_load  = 1'b1;
         ncpu_isa_pkg::STW: is_store = 1'b1;
         default: ;                                // Everything else halts
      endcase
   end

   assign in_exec = (state_q == ncpu_bus_pkg::EXEC);
   assign in_mem  = (state_q == ncpu_bus_pkg::MEM);

   always_comb begin
      state_d = state_q;
      case (state_q)
         ncpu_bus_pkg::FETCH: if (ibus_rsp_i.valid) state_d = ncpu_bus_pkg::EXEC;
         ncpu_bus_pkg::EXEC: begin
            if (is_load || is_store) state_d = ncpu_bus_pkg::MEM;
            else if (is_alu || is_beq) state_d = ncpu_bus_pkg::FETCH;
            else state_d = ncpu_bus_pkg::HALT;
         end
         ncpu_bus_pkg::MEM: if (mem_done_i) state_d = ncpu_bus_pkg::FETCH;
         default: state_d = ncpu_bus_pkg::HALT;    // Sticky
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) state_q <= ncpu_bus_pkg::FETCH;
      else           state_q <= state_d;
   end

   // Instruction register, loaded on the fetch response
   always_ff @(posedge clk_i) begin
      if (fetch_valid_o && ibus_rsp_i.valid) insn_o <= ncpu_isa_pkg::ncpu_insn_t'(ibus_rsp_i.insn);
   end

   assign fetch_valid_o = (state_q == ncpu_bus_pkg::FETCH);
   assign pc_load_o     = in_exec & is_beq & alu_res_i.taken;          // Relative branch
   assign pc_inc_o      = (in_exec & (is_alu | (is_beq & ~alu_res_i.taken)))
                        | (in_mem & mem_done_i);
   assign mem_start_o   = in_exec & (is_load | is_store);
   assign reg_we_o      = (in_exec & is_alu & alu_res_i.wb_en)
                        | (in_mem & is_load & mem_done_i);             // Load write back
   assign wb_sel_load_o = is_load;
   assign retire_o      = (in_exec & (is_alu | is_beq)) | (in_mem & mem_done_i);
   assign halted_o      = (state_q == ncpu_bus_pkg::HALT);

endmodule

//--- logic/ncpu_pc_cnt.sv
// Program counter of the core
// Steps one word on inc_i or jumps relative on load_i
// Its value is the fetch address of the instruction bus

module ncpu_pc_cnt (
   input  logic                                 clk_i,
   input  logic                                 arst_n_i,
   input  logic                                 inc_i,
   input  logic                                 load_i,
   input  logic [ncpu_isa_pkg::NCPU_IMM_W-1:0]  offset_i,   // Word offset from BEQ
   output logic [ncpu_isa_pkg::NCPU_AW-1:0]     pc_o
);
   logic [ncpu_isa_pkg::NCPU_PCW-1:0] pc_q;                 // Word address
   logic [ncpu_isa_pkg::NCPU_PCW-1:0] pc_next;              // pc plus one word
   logic [ncpu_isa_pkg::NCPU_PCW-1:0] pc_target;            // Branch destination

   assign pc_next   = pc_q + 1'b1;
   // Target is pc + 4 + imm * 4, wraps within the address space
   assign pc_target = pc_next + offset_i[ncpu_isa_pkg::NCPU_PCW-1:0];

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pc_q <= '0;                                        // Boot at address 0
      end else if (load_i) begin
         pc_q <= pc_target;                                 // Branch wins
      end else if (inc_i) begin
         pc_q <= pc_next;
      end
   end

   assign pc_o = {pc_q, 2'b00};                             // Byte address

endmodule

//--- logic/ncpu_regfile.sv
// Register file with eight words
// Two combinational read ports and one write port
// Register 0 reads as zero and drops writes

module ncpu_regfile (
   input  logic                                  clk_i,
   input  logic                                  arst_n_i,
   input  logic [ncpu_isa_pkg::NCPU_REG_AW-1:0]  rs1_addr_i,
   input  logic [ncpu_isa_pkg::NCPU_REG_AW-1:0]  rs2_addr_i,
   output logic [ncpu_isa_pkg::NCPU_DW-1:0]      rs1_data_o,
   output logic [ncpu_isa_pkg::NCPU_DW-1:0]      rs2_data_o,
   input  logic                                  we_i,
   input  logic [ncpu_isa_pkg::NCPU_REG_AW-1:0]  rd_addr_i,
   input  logic [ncpu_isa_pkg::NCPU_DW-1:0]      rd_data_i
);
   logic [ncpu_isa_pkg::NCPU_DW-1:0] regs_q [ncpu_isa_pkg::NCPU_REGS];

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < ncpu_isa_pkg::NCPU_REGS; i++) begin
            regs_q[i] <= '0;                                 // All registers cleared
         end
      end else if (we_i && (rd_addr_i != '0)) begin
         regs_q[rd_addr_i] <= rd_data_i;                     // r0 never written
      end
   end

   // Read ports
   assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
   assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

//--- logic/ncpu_alu.sv
// Execute unit of the core
// Computes register and immediate arithmetic, load/store addresses
// and the BEQ compare, all in one combinational step

module ncpu_alu (
   input  ncpu_isa_pkg::ncpu_insn_t          insn_i,
   input  logic [ncpu_isa_pkg::NCPU_DW-1:0]  op1_i,    // rs1 value
   input  logic [ncpu_isa_pkg::NCPU_DW-1:0]  op2_i,    // rs2 value
   output ncpu_isa_pkg::ncpu_alu_res_t       res_o
);
   logic [ncpu_isa_pkg::NCPU_DW-1:0] imm_sext;

   // Sign extended immediate
   assign imm_sext = {{(ncpu_isa_pkg::NCPU_DW - ncpu_isa_pkg::NCPU_IMM_W)
                       {insn_i.imm[ncpu_isa_pkg::NCPU_IMM_W-1]}}, insn_i.imm};

   always_comb begin
      res_o = '0;                                      // Default no write back
      case (insn_i.opcode)
         ncpu_isa_pkg::ADD: begin
            res_o.result = op1_i + op2_i;
            res_o.wb_en  = 1'b1;
         end
         ncpu_isa_pkg::SUB: begin
            res_o.result = op1_i - op2_i;
            res_o.wb_en  = 1'b1;
         end
         ncpu_isa_pkg::AND: begin
            res_o.result = op1_i & op2_i;
            res_o.wb_en  = 1'b1;
         end
         ncpu_isa_pkg::OR: begin
            res_o.result = op1_i | op2_i;
            res_o.wb_en  = 1'b1;
         end
         ncpu_isa_pkg::XOR: begin
            res_o.result = op1_i ^ op2_i;
            res_o.wb_en  = 1'b1;
         end
         ncpu_isa_pkg::ADDI: begin
            res_o.result = op1_i + imm_sext;
            res_o.wb_en  = 1'b1;
         end
         ncpu_isa_pkg::LDW: begin
            res_o.result = op1_i + imm_sext;           // Effective address
            res_o.wb_en  = 1'b1;                       // rd written at data response
         end
         ncpu_isa_pkg::STW: res_o.result = op1_i + imm_sext;
         ncpu_isa_pkg::BEQ: res_o.taken  = (op1_i == op2_i);
         default: ;                                    // HALT and unused codes
      endcase
   end

endmodule

//--- logic/ncpu_lsu.sv
// Load/store unit of the core
// Captures one word request on start_i, holds it on the data bus
// and reports completion with the load data on the response

module ncpu_lsu (
   input  logic                                clk_i,
   input  logic                                arst_n_i,
   input  logic                                start_i,
   input  logic                                is_store_i,
   input  logic [ncpu_isa_pkg::NCPU_AW-1:0]    addr_i,
   input  logic [ncpu_isa_pkg::NCPU_DW-1:0]    wdata_i,
   output ncpu_bus_pkg::ncpu_dbus_req_t        dbus_req_o,
   input  ncpu_bus_pkg::ncpu_dbus_rsp_t        dbus_rsp_i,
   output logic                                done_o,
   output logic [ncpu_isa_pkg::NCPU_DW-1:0]    rdata_o
);
   logic                                 valid_q;    // Request pending
   logic                                 we_q;
   logic [ncpu_isa_pkg::NCPU_AW-1:0]     addr_q;
   logic [ncpu_isa_pkg::NCPU_DW-1:0]     wdata_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_q <= 1'b0;
      end else if (start_i) begin
         valid_q <= 1'b1;                            // Valid from first MEM cycle
      end else if (done_o) begin
         valid_q <= 1'b0;                            // Drop after response
      end
   end

   // Payload stays stable while valid_q is set
   always_ff @(posedge clk_i) begin
      if (start_i) begin
         we_q    <= is_store_i;
         addr_q  <= addr_i;
         wdata_q <= wdata_i;
      end
   end

   assign dbus_req_o.valid = valid_q;
   assign dbus_req_o.we    = we_q;
   assign dbus_req_o.addr  = addr_q;
   assign dbus_req_o.wdata = wdata_q;

   assign done_o  = valid_q & dbus_rsp_i.valid;      // Zero latency allowed
   assign rdata_o = dbus_rsp_i.rdata;

endmodule

//--- logic/ncpu_core.sv
// Top level of the multi-cycle integer core
// Connects control FSM, pc, register file, execute and load/store
// units to the instruction bus and the data bus

module ncpu_core (
   input  logic                         clk_i,
   input  logic                         arst_n_i,
   output ncpu_bus_pkg::ncpu_ibus_req_t ibus_req_o,
   input  ncpu_bus_pkg::ncpu_ibus_rsp_t ibus_rsp_i,
   output ncpu_bus_pkg::ncpu_dbus_req_t dbus_req_o,
   input  ncpu_bus_pkg::ncpu_dbus_rsp_t dbus_rsp_i,
   output logic                         retire_o,
   output logic                         halted_o
);
   ncpu_isa_pkg::ncpu_insn_t          insn;        // Latched instruction
   ncpu_isa_pkg::ncpu_alu_res_t       alu_res;
   logic                              fetch_valid;
   logic                              pc_inc, pc_load;
   logic                              mem_start, mem_done;
   logic                              reg_we, wb_sel_load;
   logic [ncpu_isa_pkg::NCPU_AW-1:0]  pc;
   logic [ncpu_isa_pkg::NCPU_DW-1:0]  rs1_data, rs2_data;
   logic [ncpu_isa_pkg::NCPU_DW-1:0]  load_data, rd_data;

   ////////////////////////////////////////////////////////////
   // Control
   ////////////////////////////////////////////////////////////

   ncpu_ctrl_fsm u_ctrl (
      .clk_i(clk_i), .arst_n_i(arst_n_i), .ibus_rsp_i(ibus_rsp_i),
      .fetch_valid_o(fetch_valid), .insn_o(insn), .alu_res_i(alu_res),
      .mem_done_i(mem_done), .pc_inc_o(pc_inc), .pc_load_o(pc_load),
      .mem_start_o(mem_start), .reg_we_o(reg_we), .wb_sel_load_o(wb_sel_load),
      .retire_o(retire_o), .halted_o(halted_o));

   ////////////////////////////////////////////////////////////
   // Fetch
   ////////////////////////////////////////////////////////////

   ncpu_pc_cnt u_pc (
      .clk_i(clk_i), .arst_n_i(arst_n_i), .inc_i(pc_inc), .load_i(pc_load),
      .offset_i(insn.imm), .pc_o(pc));

   assign ibus_req_o.valid = fetch_valid;
   assign ibus_req_o.addr  = pc;

   ////////////////////////////////////////////////////////////
   // Decode and execute
   ////////////////////////////////////////////////////////////

   assign rd_data = wb_sel_load ? load_data : alu_res.result;   // Write back source

   ncpu_regfile u_regfile (
      .clk_i(clk_i), .arst_n_i(arst_n_i), .rs1_addr_i(insn.rs1), .rs2_addr_i(insn.rs2),
      .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .we_i(reg_we),
      .rd_addr_i(insn.rd), .rd_data_i(rd_data));

   ncpu_alu u_alu (
      .insn_i(insn), .op1_i(rs1_data), .op2_i(rs2_data), .res_o(alu_res));

   ////////////////////////////////////////////////////////////
   // Load/store
   ////////////////////////////////////////////////////////////

   ncpu_lsu u_lsu (
      .clk_i(clk_i), .arst_n_i(arst_n_i), .start_i(mem_start),
      .is_store_i(insn.opcode == ncpu_isa_pkg::STW),
      .addr_i(alu_res.result[ncpu_isa_pkg::NCPU_AW-1:0]), .wdata_i(rs2_data),
      .dbus_req_o(dbus_req_o), .dbus_rsp_i(dbus_rsp_i),
      .done_o(mem_done), .rdata_o(load_data));

endmodule

//--- verif/ncpu_core_asserts.sv
// Concurrent checks on the core's bus handshake and status outputs
// Bound to every ncpu_core, failures raise $error and bump fail_cnt

module ncpu_core_asserts (
   input logic                         clk_i,
   input logic                         arst_n_i,
   input ncpu_bus_pkg::ncpu_ibus_req_t ibus_req_o,
   input ncpu_bus_pkg::ncpu_ibus_rsp_t ibus_rsp_i,
   input ncpu_bus_pkg::ncpu_dbus_req_t dbus_req_o,
   input ncpu_bus_pkg::ncpu_dbus_rsp_t dbus_rsp_i,
   input logic                         retire_o,
   input logic                         halted_o
);
   int unsigned fail_cnt = 0;                      // Summed into the final verdict

   reset_quiet_a: assert property (@(posedge clk_i)
      (!arst_n_i || $rose(arst_n_i)) |-> !dbus_req_o.valid && !retire_o && !halted_o)
      else begin
         fail_cnt++;
         $error("data request, retire or halt active in or right after reset");
      end

   first_fetch_a: assert property (@(posedge clk_i)
      $rose(arst_n_i) |-> ibus_req_o.valid && (ibus_req_o.addr == '0))
      else begin
         fail_cnt++;
         $error("first fetch after reset not requested at address 0");
      end

   // Requests held stable until their response
   ibus_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      ibus_req_o.valid && !ibus_rsp_i.valid |=> ibus_req_o.valid && $stable(ibus_req_o.addr))
      else begin
         fail_cnt++;
         $error("fetch request dropped or changed before its response");
      end

   dbus_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      dbus_req_o.valid && !dbus_rsp_i.valid |=> $stable(dbus_req_o))
      else begin
         fail_cnt++;
         $error("data request dropped or changed before its response");
      end

   halt_quiet_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      halted_o |-> !ibus_req_o.valid && !dbus_req_o.valid && !retire_o)
      else begin
         fail_cnt++;
         $error("bus request or retire seen while halted");
      end

   halt_sticky_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      halted_o |=> halted_o)
      else begin
         fail_cnt++;
         $error("halted_o fell without a reset");
      end

endmodule

bind ncpu_core ncpu_core_asserts u_asserts (.*);

//--- verif/ncpu_core_tb.sv
// Testbench for the multi-cycle core
// Runs a fixed program with random bus latency against a reference
// interpreter, checks fetch addresses, stores and the retire count

module ncpu_core_tb;

   logic                         clk, arst_n;
   ncpu_bus_pkg::ncpu_ibus_req_t ibus_req;
   ncpu_bus_pkg::ncpu_ibus_rsp_t ibus_rsp;
   ncpu_bus_pkg::ncpu_dbus_req_t dbus_req;
   ncpu_bus_pkg::ncpu_dbus_rsp_t dbus_rsp;
   logic                         retire, halted;

   logic [31:0]                  imem [64];        // Program memory
   logic [31:0]                  dmem [64];        // Data memory
   logic [1:0]                   lat_tab [128];    // Fetch latencies followed by data latencies
   logic [15:0]                  exp_fetch [$];    // Reference fetch addresses
   ncpu_bus_pkg::ncpu_dbus_req_t exp_store [$];    // Reference stores in order
   int                           exp_retire, cyc;
   int                           retired = 0, errors = 0, n_fetch = 0, n_data = 0;

   ncpu_core DUT (
      .clk_i(clk), .arst_n_i(arst_n),
      .ibus_req_o(ibus_req), .ibus_rsp_i(ibus_rsp),
      .dbus_req_o(dbus_req), .dbus_rsp_i(dbus_rsp),
      .retire_o(retire), .halted_o(halted));

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;                       // Period 8
   end

   always @(negedge clk) begin
      if (arst_n && retire) retired++;             // Sampled mid cycle where outputs settle
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] encode_insn(ncpu_isa_pkg::ncpu_opc_e op, int rd, int rs1,
                                               int rs2, int imm);
      ncpu_isa_pkg::ncpu_insn_t insn;
      insn        = '0;
      insn.opcode = op;
      insn.rd     = 3'(rd);
      insn.rs1    = 3'(rs1);
      insn.rs2    = 3'(rs2);
      insn.imm    = 16'(imm);
      return insn;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   // Instruction set interpreter that fills the expected queues
   task automatic run_reference();
      logic [31:0]                  r [8];
      logic [31:0]                  mem [64];
      logic [31:0]                  ea;
      ncpu_isa_pkg::ncpu_insn_t     insn;
      ncpu_bus_pkg::ncpu_dbus_req_t st;
      int                           pc, pc_next;
      bit                           stop;
      r          = '{default: '0};
      mem        = dmem;
      pc         = 0;
      stop       = 1'b0;
      exp_retire = 0;
      for (int step = 0; step < 1000 && !stop; step++) begin
         exp_fetch.push_back(16'(pc * 4));
         insn    = ncpu_isa_pkg::ncpu_insn_t'(imem[pc % 64]);
         ea      = r[insn.rs1] + {{16{insn.imm[15]}}, insn.imm};   // rs1 + sext(imm)
         pc_next = pc + 1;
         case (insn.opcode)
            ncpu_isa_pkg::ADD:  r[insn.rd] = r[insn.rs1] + r[insn.rs2];
            ncpu_isa_pkg::SUB:  r[insn.rd] = r[insn.rs1] - r[insn.rs2];
            ncpu_isa_pkg::AND:  r[insn.rd] = r[insn.rs1] & r[insn.rs2];
            ncpu_isa_pkg::OR:   r[insn.rd] = r[insn.rs1] | r[insn.rs2];
            ncpu_isa_pkg::XOR:  r[insn.rd] = r[insn.rs1] ^ r[insn.rs2];
            ncpu_isa_pkg::ADDI: r[insn.rd] = ea;
            ncpu_isa_pkg::LDW:  r[insn.rd] = mem[ea[7:2]];
            ncpu_isa_pkg::STW: begin
               mem[ea[7:2]] = r[insn.rs2];
               st = '{valid: 1'b1, we: 1'b1, addr: ea[15:0], wdata: r[insn.rs2]};
               exp_store.push_back(st);
            end
            ncpu_isa_pkg::BEQ: begin
               if (r[insn.rs1] == r[insn.rs2]) pc_next = pc + 1 + $signed(insn.imm);
            end
            default: stop = 1'b1;                  // HALT and unused codes
         endcase
         r[0] = '0;                                // r0 stays zero
         if (!stop) exp_retire++;
         pc = pc_next;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus and final verdict
   ////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(32'h9a232c36));               // Only seed of the run
      arst_n   = 1'b0;
      ibus_rsp = '0;
      dbus_rsp = '0;
      for (int i = 0; i < 128; i++)
         lat_tab[i] = 2'($urandom % 4);            // 0 to 3 extra cycles
      for (int i = 0; i < 64; i++) begin
         imem[i] = {4'hf, 28'(i)};                 // HALT filler tagged with its index
         dmem[i] = {16'hc3a5, 16'(i * 4)};         // Low half is the byte address
      end
      imem[0]  = encode_insn(ncpu_isa_pkg::ADDI, 1, 0, 0, 5);
      imem[1]  = encode_insn(ncpu_isa_pkg::ADDI, 2, 0, 0, -3);
      imem[2]  = encode_insn(ncpu_isa_pkg::ADD,  3, 1, 2, 0);
      imem[3]  = encode_insn(ncpu_isa_pkg::SUB,  4, 3, 2, 0);
      imem[4]  = encode_insn(ncpu_isa_pkg::AND,  5, 4, 2, 0);
      imem[5]  = encode_insn(ncpu_isa_pkg::OR,   6, 5, 3, 0);
      imem[6]  = encode_insn(ncpu_isa_pkg::XOR,  7, 6, 2, 0);
      imem[7]  = encode_insn(ncpu_isa_pkg::ADDI, 0, 7, 0, 9);     // Dropped write to r0
      imem[8]  = encode_insn(ncpu_isa_pkg::STW,  0, 0, 7, 'h40);
      imem[9]  = encode_insn(ncpu_isa_pkg::STW,  0, 0, 0, 'h44);  // r0 reads back zero
      imem[10] = encode_insn(ncpu_isa_pkg::LDW,  1, 0, 0, 'h40);
      imem[11] = encode_insn(ncpu_isa_pkg::STW,  0, 0, 1, 'h48);
      imem[12] = encode_insn(ncpu_isa_pkg::LDW,  2, 0, 0, 'h80);  // Preloaded word
      imem[13] = encode_insn(ncpu_isa_pkg::STW,  0, 0, 2, 'h4c);
      imem[14] = encode_insn(ncpu_isa_pkg::ADDI, 4, 0, 0, 3);     // Loop count
      imem[15] = encode_insn(ncpu_isa_pkg::ADDI, 5, 5, 0, 1);
      imem[16] = encode_insn(ncpu_isa_pkg::ADDI, 4, 4, 0, -1);
      imem[17] = encode_insn(ncpu_isa_pkg::BEQ,  0, 4, 0, 1);     // Exit over the back branch
      imem[18] = encode_insn(ncpu_isa_pkg::BEQ,  0, 0, 0, -4);    // Back to word 15
      imem[19] = encode_insn(ncpu_isa_pkg::STW,  0, 0, 5, 'h50);
      imem[20] = encode_insn(ncpu_isa_pkg::HALT, 0, 0, 0, 0);
      run_reference();

      repeat (16) @(posedge clk);
      #1;
      arst_n = 1'b1;

      for (cyc = 0; cyc < 4000 && !halted; cyc++)
         @(negedge clk);
      if (!halted) begin
         errors++;
         $display("Timeout: halted_o did not rise within %0d cycles", cyc);
      end
      repeat (8) @(negedge clk);                   // Quiet time after halt

      check_value("retire_o count", retired, exp_retire);
      check_value("pending fetch count", exp_fetch.size(), 0);
      check_value("pending store count", exp_store.size(), 0);
      $display("Errors: %0d checks, %0d assertions", errors, DUT.u_asserts.fail_cnt);
      if (errors == 0 && DUT.u_asserts.fail_cnt == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Bus memory models
   ////////////////////////////////////////////////////////////

   initial begin : ibus_model
      for (int i = 0; i < 64 && arst_n !== 1'b1; i++)
         @(posedge clk);
      #1;
      forever begin
         if (ibus_req.valid) begin
            if (exp_fetch.size() == 0) begin
               errors++;
               $display("Fetch at %h beyond the end of the reference program", ibus_req.addr);
            end else
               check_value("ibus_req_o.addr", ibus_req.addr, exp_fetch.pop_front());
            repeat (lat_tab[n_fetch % 64]) begin
               @(posedge clk);
               #1;
            end
            n_fetch++;
            ibus_rsp.valid = 1'b1;
            ibus_rsp.insn  = imem[ibus_req.addr[7:2]];
         end
         @(posedge clk);
         #1;
         ibus_rsp.valid = 1'b0;                    // One cycle response
      end
   end

   initial begin : dbus_model
      ncpu_bus_pkg::ncpu_dbus_req_t st_exp;
      for (int i = 0; i < 64 && arst_n !== 1'b1; i++)
         @(posedge clk);
      #1;
      forever begin
         if (dbus_req.valid) begin
            repeat (lat_tab[64 + n_data % 64]) begin
               @(posedge clk);
               #1;
            end
            n_data++;
            dbus_rsp.valid = 1'b1;
            if (dbus_req.we) begin
               if (exp_store.size() == 0) begin
                  errors++;
                  $display("Store to %h that the reference program never makes",
                           dbus_req.addr);
               end else begin
                  st_exp = exp_store.pop_front();
                  check_value("dbus_req_o.addr", dbus_req.addr, st_exp.addr);
                  check_value("dbus_req_o.wdata", dbus_req.wdata, st_exp.wdata);
               end
               dmem[dbus_req.addr[7:2]] = dbus_req.wdata;
            end else begin
               dbus_rsp.rdata = dmem[dbus_req.addr[7:2]];
            end
         end
         @(posedge clk);
         #1;
         dbus_rsp.valid = 1'b0;
      end
   end

endmodule

//--- ncpu_core.f
logic/ncpu_isa_pkg.sv
logic/ncpu_bus_pkg.sv
logic/ncpu_ctrl_fsm.sv
logic/ncpu_pc_cnt.sv
logic/ncpu_regfile.sv
logic/ncpu_alu.sv
logic/ncpu_lsu.sv
logic/ncpu_core.sv
verif/ncpu_core_asserts.sv
verif/ncpu_core_tb.sv
